// File: logic/ntm_trainer_pkg.sv
// Shared job opcode and FSM state types of the controller gradient engine
`default_nettype none

package ntm_trainer_pkg;

  ////////////////////////////////////////
  // Job opcodes
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_WEIGHT    = 2'd0,  // d(t) x x(t), gives dW
    OP_RECURRENT = 2'd1,  // d(t+1) x h(t), gives dU
    OP_BIAS      = 2'd2   // d(t) x 1, gives db
  } trainer_op_t;

  ////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////

  // Feeder sequencing
  typedef enum logic [2:0] {
    FD_IDLE,
    FD_CLEAR,     // Accumulators wiped
    FD_LOAD_D,    // Error elements, one per lane
    FD_STREAM_X,  // Operand elements, one per column
    FD_BIAS_ONE,  // Constant operand issued
    FD_FLUSH      // Let the last products land
  } feeder_state_t;

  // Collector drain
  typedef enum logic [1:0] {
    CL_IDLE,
    CL_STREAM,
    CL_DONE
  } collector_state_t;

endpackage

`default_nettype wire

// File: logic/gradient_feeder.sv
// Gradient feeder: sequences a job, routes error elements to lanes and broadcasts operands
`timescale 1ns/1ns
`default_nettype none

module gradient_feeder
  import ntm_trainer_pkg::*;
#(
  parameter int DATA_SIZE = 16,
  parameter int LANES     = 4,
  parameter int MAX_COLS  = 8,
  localparam int COL_W    = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1,
  localparam int COUNT_W  = $clog2(MAX_COLS + 1)
) (
  input  wire                         CLK,
  input  wire                         RST,

  // Job control
  input  wire                         START,
  input  wire trainer_op_t            OPCODE,
  input  wire        [DATA_SIZE-1:0]  SIZE_X,
  input  wire        [DATA_SIZE-1:0]  SIZE_T,

  // Error and operand streams
  input  wire                         D_IN_ENABLE,
  input  wire signed [DATA_SIZE-1:0]  D_IN,
  input  wire                         X_IN_ENABLE,
  input  wire signed [DATA_SIZE-1:0]  X_IN,

  // Lane array controls
  output logic                        lane_clear,
  output logic       [LANES-1:0]      d_load,
  output logic signed [DATA_SIZE-1:0] d_value,
  output logic                        op_valid,
  output logic       [COL_W-1:0]      op_col,
  output logic signed [DATA_SIZE-1:0] op_value,

  // Hand-off to the collector
  output logic                        drain_start,
  output logic       [COUNT_W-1:0]    drain_cols
);

  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  feeder_state_t               state;
  feeder_state_t               d_next;     // Where the last error element leads
  trainer_op_t                 op_r;       // Job latched at START
  logic        [COUNT_W-1:0]   size_x_r;
  logic        [DATA_SIZE-1:0] size_t_r;
  logic        [DATA_SIZE-1:0] step_cnt;
  logic        [DATA_SIZE-1:0] step_next;
  logic        [LANE_W-1:0]    lane_cnt;
  logic        [COUNT_W-1:0]   col_cnt;
  logic                        flush_cnt;

  logic                        x_valid_r;
  logic        [COL_W-1:0]     x_col_r;
  logic signed [DATA_SIZE-1:0] x_value_r;

  // h(t) of the previous step, for the one-step offset of dU
  logic signed [DATA_SIZE-1:0] h_buf [MAX_COLS];

  logic d_accept;
  logic x_accept;
  logic last_lane;
  logic last_col;
  logic last_step;
  logic bias_done;

  ////////////////////////////////////////
  // Strobe qualification
  ////////////////////////////////////////

  assign bias_done = (step_cnt == size_t_r);  // All bias steps counted

  // D accepted right from the clear cycle, stray strobes dropped
  assign d_accept = D_IN_ENABLE &&
                    ((state == FD_CLEAR) || (state == FD_LOAD_D) ||
                     ((state == FD_BIAS_ONE) && !bias_done));
  assign x_accept = X_IN_ENABLE && (state == FD_STREAM_X);

  assign last_lane = (lane_cnt == LANE_W'(LANES - 1));
  assign last_col  = (col_cnt + 1'b1 == size_x_r);
  assign step_next = step_cnt + 1'b1;
  assign last_step = (step_next == size_t_r);

  // Bias rows take no X, the constant goes out instead
  assign d_next = (op_r == OP_BIAS) ? FD_BIAS_ONE : FD_STREAM_X;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= FD_IDLE;
      op_r        <= OP_WEIGHT;
      size_x_r    <= '0;
      size_t_r    <= '0;
      step_cnt    <= '0;
      lane_cnt    <= '0;
      col_cnt     <= '0;
      flush_cnt   <= 1'b0;
      d_load      <= '0;
      x_valid_r   <= 1'b0;
      drain_start <= 1'b0;
      drain_cols  <= '0;
    end else begin
      // Single-cycle strobes by default
      d_load      <= '0;
      x_valid_r   <= 1'b0;
      drain_start <= 1'b0;

      if (d_accept) begin
        d_load   <= LANES'(1) << lane_cnt;  // Row k loads one cycle after strobe k
        lane_cnt <= last_lane ? '0 : lane_cnt + 1'b1;
      end

      if (x_accept) begin
        // Step 0 of dU only fills the buffer
        x_valid_r <= !((op_r == OP_RECURRENT) && (step_cnt == '0));
        col_cnt   <= last_col ? '0 : col_cnt + 1'b1;
      end

      case (state)
        FD_IDLE: begin
          if (START) begin
            op_r     <= OPCODE;
            size_x_r <= SIZE_X[COUNT_W-1:0];
            size_t_r <= SIZE_T;
            step_cnt <= '0;
            lane_cnt <= '0;
            col_cnt  <= '0;
            state    <= FD_CLEAR;
          end
        end

        FD_CLEAR: state <= FD_LOAD_D;  // One cycle of lane_clear

        FD_LOAD_D: ;  // Left by the last error element below

        FD_STREAM_X: begin
          if (x_accept && last_col) begin
            step_cnt <= step_next;
            state    <= last_step ? FD_FLUSH : FD_LOAD_D;
          end
        end

        FD_BIAS_ONE: state <= bias_done ? FD_FLUSH : FD_LOAD_D;

        FD_FLUSH: begin
          // Two idle cycles, then hand over
          flush_cnt <= ~flush_cnt;
          if (flush_cnt) begin
            drain_start <= 1'b1;
            drain_cols  <= (op_r == OP_BIAS) ? COUNT_W'(1) : size_x_r;
            state       <= FD_IDLE;
          end
        end

        default: state <= FD_IDLE;
      endcase

      // Last error element of a step overrides the state walk
      if (d_accept && last_lane) begin
        state <= d_next;
        if (op_r == OP_BIAS) begin
          step_cnt <= step_next;  // Bias step ends with its D strobes
        end
      end
    end
  end

  ////////////////////////////////////////
  // Operand path
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (d_accept) begin
      d_value <= D_IN;
    end
    if (x_accept) begin
      x_col_r <= col_cnt[COL_W-1:0];
      if (op_r == OP_RECURRENT) begin
        x_value_r                   <= h_buf[col_cnt[COL_W-1:0]];  // h(t-1)
        h_buf[col_cnt[COL_W-1:0]]   <= X_IN;                       // Keep h(t)
      end else begin
        x_value_r <= X_IN;
      end
    end
  end

  assign lane_clear = (state == FD_CLEAR);

  // Constant one at column 0 while in BIAS_ONE
  assign op_valid = x_valid_r || (state == FD_BIAS_ONE);
  assign op_col   = (state == FD_BIAS_ONE) ? '0 : x_col_r;
  assign op_value = (state == FD_BIAS_ONE) ? DATA_SIZE'(1) : x_value_r;

endmodule

`default_nettype wire

// File: logic/gradient_lane.sv
// Gradient lane: one output row, holding its error element and per-column accumulators
`timescale 1ns/1ns
`default_nettype none

module gradient_lane #(
  parameter int DATA_SIZE = 16,
  parameter int MAX_COLS  = 8,
  localparam int ACC_SIZE = 2 * DATA_SIZE + 8,
  localparam int COL_W    = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1
) (
  input  wire                         CLK,
  input  wire                         RST,

  // From the feeder
  input  wire                         lane_clear,
  input  wire                         d_load,
  input  wire signed [DATA_SIZE-1:0]  d_value,
  input  wire                         op_valid,
  input  wire        [COL_W-1:0]      op_col,
  input  wire signed [DATA_SIZE-1:0]  op_value,

  // Read port for the collector
  input  wire        [COL_W-1:0]      rd_col,
  output logic signed [ACC_SIZE-1:0]  rd_value
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic signed [DATA_SIZE-1:0]   d_reg;    // Error element d(t;l) of this row
  logic signed [DATA_SIZE-1:0]   d_eff;
  logic signed [2*DATA_SIZE-1:0] product;
  logic signed [ACC_SIZE-1:0]    acc [MAX_COLS];

  ////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////

  // Bias operand can land together with the row's own load
  assign d_eff   = d_load ? d_value : d_reg;
  assign product = d_eff * op_value;  // Full signed product

  ////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      d_reg <= '0;
      for (int c = 0; c < MAX_COLS; c++) begin
        acc[c] <= '0;
      end
    end else begin
      if (d_load) begin
        d_reg <= d_value;
      end

      if (lane_clear) begin
        // New job starts from zero
        for (int c = 0; c < MAX_COLS; c++) begin
          acc[c] <= '0;
        end
      end else if (op_valid) begin
        acc[op_col] <= acc[op_col] + product;  // Sign-extended to ACC_SIZE
      end
    end
  end

  assign rd_value = acc[rd_col];  // Combinational read, column set by collector

endmodule

`default_nettype wire

// File: logic/gradient_collector.sv
// Gradient collector: drains every row's accumulators as one stream and flags completion
`timescale 1ns/1ns
`default_nettype none

module gradient_collector
  import ntm_trainer_pkg::*;
#(
  parameter int DATA_SIZE = 16,
  parameter int LANES     = 4,
  parameter int MAX_COLS  = 8,
  localparam int ACC_SIZE = 2 * DATA_SIZE + 8,
  localparam int COL_W    = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1,
  localparam int COUNT_W  = $clog2(MAX_COLS + 1)
) (
  input  wire                         CLK,
  input  wire                         RST,

  // From the feeder
  input  wire                         drain_start,
  input  wire        [COUNT_W-1:0]    drain_cols,

  // Lane read ports
  output logic       [COL_W-1:0]      rd_col,
  input  wire signed [ACC_SIZE-1:0]   rd_value [LANES],

  // Output stream
  output logic                        OUT_L_ENABLE,
  output logic                        OUT_X_ENABLE,
  output logic signed [ACC_SIZE-1:0]  DATA_OUT,
  output logic                        READY
);

  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  collector_state_t     state;
  logic [COUNT_W-1:0]   cols_r;    // Columns per row for this drain
  logic [COUNT_W-1:0]   cols_now;
  logic [COUNT_W-1:0]   col_cnt;
  logic [LANE_W-1:0]    row_cnt;

  logic emit;      // One element leaves this cycle
  logic last_col;
  logic last_row;

  // First element goes out straight from drain_start
  assign emit     = (state == CL_STREAM) || ((state == CL_IDLE) && drain_start);
  assign cols_now = (state == CL_IDLE) ? drain_cols : cols_r;
  assign last_col = (col_cnt + 1'b1 == cols_now);
  assign last_row = (row_cnt == LANE_W'(LANES - 1));

  assign rd_col = col_cnt[COL_W-1:0];  // Same column to every lane

  ////////////////////////////////////////
  // Drain FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= CL_IDLE;
      cols_r       <= '0;
      col_cnt      <= '0;
      row_cnt      <= '0;
      OUT_L_ENABLE <= 1'b0;
      OUT_X_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      OUT_X_ENABLE <= emit;                      // Every element
      OUT_L_ENABLE <= emit && (col_cnt == '0);   // Row start only
      READY        <= 1'b0;

      case (state)
        CL_IDLE: begin
          if (drain_start) begin
            cols_r <= drain_cols;
            state  <= CL_STREAM;
          end
        end

        CL_STREAM: ;  // Walk handled below

        CL_DONE: begin
          READY <= 1'b1;  // Cycle after the last element
          state <= CL_IDLE;
        end

        default: state <= CL_IDLE;
      endcase

      // Row-major walk, columns inside rows
      if (emit) begin
        if (last_col) begin
          col_cnt <= '0;
          if (last_row) begin
            row_cnt <= '0;
            state   <= CL_DONE;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // Output register, row picks the lane
  always_ff @(posedge CLK) begin
    if (emit) begin
      DATA_OUT <= rd_value[row_cnt];
    end
  end

endmodule

`default_nettype wire

// File: logic/ntm_gradient_trainer.sv
// Controller gradient engine top: feeder, lane array and collector for dW, dU and db
`timescale 1ns/1ns
`default_nettype none

module ntm_gradient_trainer
  import ntm_trainer_pkg::*;
#(
  parameter int DATA_SIZE = 16,  // Element width
  parameter int LANES     = 4,   // Row count L
  parameter int MAX_COLS  = 8,   // Largest operand length
  localparam int ACC_SIZE = 2 * DATA_SIZE + 8
) (
  input  wire                         CLK,
  input  wire                         RST,

  // Job control
  input  wire                         START,
  input  wire trainer_op_t            OPCODE,
  input  wire        [DATA_SIZE-1:0]  SIZE_X,
  input  wire        [DATA_SIZE-1:0]  SIZE_T,

  // Input streams
  input  wire                         D_IN_ENABLE,
  input  wire signed [DATA_SIZE-1:0]  D_IN,
  input  wire                         X_IN_ENABLE,
  input  wire signed [DATA_SIZE-1:0]  X_IN,

  // Output stream
  output logic                        OUT_L_ENABLE,
  output logic                        OUT_X_ENABLE,
  output logic signed [ACC_SIZE-1:0]  DATA_OUT,
  output logic                        READY
);

  localparam int COL_W   = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;
  localparam int COUNT_W = $clog2(MAX_COLS + 1);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Feeder to lanes
  logic                        lane_clear;
  logic        [LANES-1:0]     d_load;
  logic signed [DATA_SIZE-1:0] d_value;
  logic                        op_valid;
  logic        [COL_W-1:0]     op_col;
  logic signed [DATA_SIZE-1:0] op_value;

  // Feeder to collector
  logic                        drain_start;
  logic        [COUNT_W-1:0]   drain_cols;

  // Collector and lane read ports
  logic        [COL_W-1:0]     rd_col;
  logic signed [ACC_SIZE-1:0]  rd_value [LANES];

  ////////////////////////////////////////
  // Feeder
  ////////////////////////////////////////

  gradient_feeder #(
    .DATA_SIZE(DATA_SIZE),
    .LANES    (LANES),
    .MAX_COLS (MAX_COLS)
  ) i_feeder (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .OPCODE     (OPCODE),
    .SIZE_X     (SIZE_X),
    .SIZE_T     (SIZE_T),
    .D_IN_ENABLE(D_IN_ENABLE),
    .D_IN       (D_IN),
    .X_IN_ENABLE(X_IN_ENABLE),
    .X_IN       (X_IN),
    .lane_clear (lane_clear),
    .d_load     (d_load),
    .d_value    (d_value),
    .op_valid   (op_valid),
    .op_col     (op_col),
    .op_value   (op_value),
    .drain_start(drain_start),
    .drain_cols (drain_cols)
  );

  // One accumulation lane per row l
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    gradient_lane #(
      .DATA_SIZE(DATA_SIZE),
      .MAX_COLS (MAX_COLS)
    ) i_lane (
      .CLK       (CLK),
      .RST       (RST),
      .lane_clear(lane_clear),
      .d_load    (d_load[l]),  // Own load bit
      .d_value   (d_value),
      .op_valid  (op_valid),
      .op_col    (op_col),
      .op_value  (op_value),
      .rd_col    (rd_col),
      .rd_value  (rd_value[l])
    );
  end

  ////////////////////////////////////////
  // Collector
  ////////////////////////////////////////

  gradient_collector #(
    .DATA_SIZE(DATA_SIZE),
    .LANES    (LANES),
    .MAX_COLS (MAX_COLS)
  ) i_collector (
    .CLK         (CLK),
    .RST         (RST),
    .drain_start (drain_start),
    .drain_cols  (drain_cols),
    .rd_col      (rd_col),
    .rd_value    (rd_value),
    .OUT_L_ENABLE(OUT_L_ENABLE),
    .OUT_X_ENABLE(OUT_X_ENABLE),
    .DATA_OUT    (DATA_OUT),
    .READY       (READY)
  );

endmodule

`default_nettype wire

// File: tb/ntm_trainer_tb.sv
// Testbench for the controller gradient engine, replays the case file and checks the stream
`timescale 1ns/1ns
`default_nettype none

module ntm_trainer_tb
  import ntm_trainer_pkg::*;
;

  localparam int DATA_SIZE  = 16;
  localparam int LANES      = 4;
  localparam int MAX_COLS   = 8;
  localparam int ACC_SIZE   = 2 * DATA_SIZE + 8;
  localparam int CLK_PERIOD = 8;
  localparam int WAIT_LIMIT = 200;  // Cycles allowed from last strobe to READY

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                        CLK;
  logic                        RST;
  logic                        START;
  trainer_op_t                 OPCODE;
  logic        [DATA_SIZE-1:0] SIZE_X;
  logic        [DATA_SIZE-1:0] SIZE_T;
  logic                        D_IN_ENABLE;
  logic signed [DATA_SIZE-1:0] D_IN;
  logic                        X_IN_ENABLE;
  logic signed [DATA_SIZE-1:0] X_IN;
  logic                        OUT_L_ENABLE;
  logic                        OUT_X_ENABLE;
  logic signed [ACC_SIZE-1:0]  DATA_OUT;
  logic                        READY;

  longint tokens[$];    // Every number of the case file, in order
  longint expect_q[$];  // Expected stream of the running case
  logic [31:0] lfsr_state;
  int          case_cnt;

  ntm_gradient_trainer #(
    .DATA_SIZE(DATA_SIZE),
    .LANES    (LANES),
    .MAX_COLS (MAX_COLS)
  ) i_dut (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .OPCODE      (OPCODE),
    .SIZE_X      (SIZE_X),
    .SIZE_T      (SIZE_T),
    .D_IN_ENABLE (D_IN_ENABLE),
    .D_IN        (D_IN),
    .X_IN_ENABLE (X_IN_ENABLE),
    .X_IN        (X_IN),
    .OUT_L_ENABLE(OUT_L_ENABLE),
    .OUT_X_ENABLE(OUT_X_ENABLE),
    .DATA_OUT    (DATA_OUT),
    .READY       (READY)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input longint actual, input longint expected);
    if (actual != expected) begin
      $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // Galois form, one bit out per step
  function automatic bit lfsr_step();
    bit out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  task automatic idle_gap();
    int gap;
    gap = lfsr_step();
    gap = 2 * gap + lfsr_step();  // 0 to 3 idle cycles
    repeat (gap) @(negedge CLK);
  endtask

  // Each strobe lasts one cycle, driven on the falling edge
  task automatic send_d(input longint value);
    idle_gap();
    D_IN_ENABLE = 1'b1;
    D_IN        = DATA_SIZE'(value);
    @(negedge CLK);
    D_IN_ENABLE = 1'b0;
  endtask

  task automatic send_x(input longint value);
    idle_gap();
    X_IN_ENABLE = 1'b1;
    X_IN        = DATA_SIZE'(value);
    @(negedge CLK);
    X_IN_ENABLE = 1'b0;
  endtask

  // Signed decimals split on anything else
  task automatic parse_line(input string line);
    longint value;
    bit     negative;
    bit     in_number;
    byte    ch;
    int     i;
    value     = 0;
    negative  = 1'b0;
    in_number = 1'b0;
    for (i = 0; i <= line.len(); i++) begin
      ch = (i < line.len()) ? line.getc(i) : 8'h20;  // Extra blank closes the last number
      if (ch == "-") begin
        negative = 1'b1;
      end else if (ch >= "0" && ch <= "9") begin
        value     = value * 10 + (int'(ch) - 48);
        in_number = 1'b1;
      end else begin
        if (in_number) begin
          tokens.push_back(negative ? -value : value);
        end
        value     = 0;
        negative  = 1'b0;
        in_number = 1'b0;
      end
    end
  endtask

  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen("tb/trainer_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file tb/trainer_cases.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin  // Skip comment lines
          parse_line(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic take_token(output longint value);
    if (tokens.size() == 0) begin
      $display("The case file ends in the middle of a case");
      value = 0;
      abort_run();
    end else begin
      value = tokens.pop_front();
    end
  endtask

  ////////////////////////////////////////
  // Output checking
  ////////////////////////////////////////

  task automatic collect_output(input int cols, input int total);
    int cycles;
    int n;
    bit done;
    bit last_x;
    cycles = 0;
    n      = 0;
    done   = 1'b0;
    last_x = 1'b0;
    while (!done) begin
      @(negedge CLK);  // Outputs settled since the rising edge
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timeout, READY did not arrive within %0d cycles", WAIT_LIMIT);
        abort_run();
      end else if (OUT_X_ENABLE) begin
        if (n >= total) begin
          $display("The DUT sent more than %0d output elements", total);
          abort_run();
        end else begin
          check_value("DATA_OUT", DATA_OUT, expect_q[n]);
          check_value("OUT_L_ENABLE", OUT_L_ENABLE, (n % cols) == 0);  // Row start
          check_value("READY", READY, 0);
          n++;
        end
      end else begin
        check_value("OUT_L_ENABLE", OUT_L_ENABLE, 0);
        if (READY) begin
          check_value("output element count", n, total);
          check_value("OUT_X_ENABLE before READY", last_x, 1);  // Last element just before
          done = 1'b1;
        end
      end
      last_x = OUT_X_ENABLE;
    end
    @(negedge CLK);
    check_value("READY", READY, 0);  // Single pulse
    check_value("OUT_X_ENABLE", OUT_X_ENABLE, 0);
  endtask

  ////////////////////////////////////////
  // One job from the case file
  ////////////////////////////////////////

  task automatic run_case();
    longint      op;
    longint      size_x;
    longint      steps;
    longint      strays;
    longint      value;
    longint      stray_q[$];
    trainer_op_t op_code;
    int          cols;
    int          total;
    int          i;
    int          t;
    take_token(op);
    take_token(size_x);
    take_token(steps);
    take_token(strays);
    op_code = trainer_op_t'(op[1:0]);
    cols    = (op_code == OP_BIAS) ? 1 : int'(size_x);  // Bias drains one column
    total   = LANES * cols;
    $display("Case %0d: opcode %0d, %0d columns, %0d steps", case_cnt, op, size_x, steps);

    // Engine idle, these X strobes go nowhere
    for (i = 0; i < strays; i++) begin
      take_token(value);
      stray_q.push_back(value);
      send_x(value);
    end

    START  = 1'b1;
    OPCODE = op_code;
    SIZE_X = DATA_SIZE'(size_x);
    SIZE_T = DATA_SIZE'(steps);
    @(negedge CLK);
    START  = 1'b0;

    // Same strobes again while the feeder waits for error elements
    for (i = 0; i < stray_q.size(); i++) begin
      send_x(stray_q[i]);
    end

    for (t = 0; t < steps; t++) begin
      for (i = 0; i < LANES; i++) begin  // Row 0 first
        take_token(value);
        send_d(value);
      end
      if (op_code != OP_BIAS) begin
        for (i = 0; i < size_x; i++) begin
          take_token(value);
          send_x(value);
        end
      end
    end

    expect_q.delete();
    for (i = 0; i < total; i++) begin
      take_token(value);
      expect_q.push_back(value);
    end
    collect_output(cols, total);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    RST         = 1'b1;
    START       = 1'b0;
    OPCODE      = OP_WEIGHT;
    SIZE_X      = '0;
    SIZE_T      = '0;
    D_IN_ENABLE = 1'b0;
    D_IN        = '0;
    X_IN_ENABLE = 1'b0;
    X_IN        = '0;
    lfsr_state  = 32'hb8ff_71cb;
    case_cnt    = 0;

    load_cases();

    repeat (10) @(negedge CLK);
    // Quiet outputs and lane controls under reset
    check_value("READY", READY, 0);
    check_value("OUT_L_ENABLE", OUT_L_ENABLE, 0);
    check_value("OUT_X_ENABLE", OUT_X_ENABLE, 0);
    check_value("lane_clear", i_dut.lane_clear, 0);
    check_value("d_load", i_dut.d_load, 0);
    check_value("op_valid", i_dut.op_valid, 0);
    RST = 1'b0;
    @(negedge CLK);

    while (tokens.size() > 0) begin
      run_case();
      case_cnt++;
    end

    if (case_cnt == 0) begin
      $display("No cases found in the case file");
      abort_run();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: ntm_trainer.f
logic/ntm_trainer_pkg.sv
logic/gradient_feeder.sv
logic/gradient_lane.sv
logic/gradient_collector.sv
logic/ntm_gradient_trainer.sv
tb/ntm_trainer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the gradient engine testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

# Compile RTL and testbench into one executable
verilator --binary --timing -Wno-fatal \
  --top-module ntm_trainer_tb \
  --Mdir "$OBJ" \
  -f ntm_trainer.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Run from the project root so the case file path resolves
"./$OBJ/Vntm_trainer_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failing check, see $LOG"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tb/trainer_cases.txt
# Signed decimal fields, lines starting with # are skipped
# Job line: opcode (0 weight, 1 recurrent, 2 bias), size_x, size_t, stray X count
# Then stray X values, per step 4 error values and size_x operands (none for bias),
# then the expected output stream row by row, 4 rows times the column count

# Weight job, 3 columns, 2 steps
0 3 2 0
1 -2 3 4
5 6 -7
2 1 -1 0
1 -3 2
7 0 -3
-9 -15 16
14 21 -23
20 24 -28

# Recurrent job, step 0 errors and last operand drop out
1 2 3 0
9 9 9 9
2 -1
1 2 -3 4
3 5
-2 1 0 3
7 7
-4 -11
7 3
-6 3
17 11

# Bias job, row sums of the errors
2 0 3 0
1 -4 100 7
2 5 -50 -7
3 6 25 1
6 7 75 1

# Stray X before START, then a short weight job
0 2 1 3
111 -222 333
3 -1 2 5
4 -6
12 -18
-4 6
8 -12
20 -30

# Full-scale operands, sums past 32 bits
0 1 3 0
32767 -32768 -32768 1
32767
32767 -32768 -32768 1
32767
32767 -32768 -32768 1
32767
3221028867 -3221127168 -3221127168 98301

# All 8 columns in one step
0 8 1 0
1 -1 2 0
1 2 3 4 5 6 7 8
1 2 3 4 5 6 7 8
-1 -2 -3 -4 -5 -6 -7 -8
2 4 6 8 10 12 14 16
0 0 0 0 0 0 0 0
